// File: hw/spi_pkg.sv
//##########################################################################
// shared constants for the spi slave: opcodes, address map, id byte
// packed union for a received byte (command view and data view)
//##########################################################################
`default_nettype none

package spi_pkg;

   //##########################################################################
   // address map
   //##########################################################################

   localparam int ADDR_W    = 6;                  // register address width
   localparam int REG_COUNT = 1 << ADDR_W;        // 64 byte registers

   localparam logic [ADDR_W-1:0] CTRL_ADDR = 6'd0;   // mirrored on ctrl_out
   localparam logic [ADDR_W-1:0] ID_ADDR   = 6'd63;  // read-only id register

   localparam logic [7:0] ID_VALUE = 8'h5a;       // identification byte

   //##########################################################################
   // command byte opcodes
   //##########################################################################

   // 2'b01 and 2'b11 are reserved: no write, miso stays low
   localparam logic [1:0] OP_WR = 2'b00;
   localparam logic [1:0] OP_RD = 2'b10;

   // frame states
   localparam logic ST_CMD  = 1'b0;               // first byte of frame
   localparam logic ST_DATA = 1'b1;               // every later byte

   //##########################################################################
   // byte formats
   //##########################################################################

   // command byte, opcode in the two top bits
   typedef struct packed {
      logic [1:0]        op;
      logic [ADDR_W-1:0] addr;
   } spi_cmd_t;

   // one received byte, read as a command or as plain data
   typedef union packed {
      spi_cmd_t   cmd;                            // first byte of frame
      logic [7:0] data;                           // payload bytes
   } spi_byte_u;

endpackage

`default_nettype wire

// File: hw/spi_slave_io.sv
//##########################################################################
// spi slave framing: command/data fsm, bit counter, receive shifter,
// command and auto-increment address register, regfile strobes
//##########################################################################
`timescale 1ns/10ps
`default_nettype none

module spi_slave_io (
   input  wire logic                        sclk,       // serial clock, mode 0
   input  wire logic                        ss,         // high = deselected, resets frame
   input  wire logic                        mosi,
   input  wire logic                        spi_en,     // gates all shifting
   input  wire logic                        lsbfirst,
   output      logic [spi_pkg::ADDR_W-1:0]  reg_addr,
   output      logic [7:0]                  reg_wdata,
   output      logic                        reg_write,  // one cycle per write byte
   output      logic                        tx_load     // one cycle per read byte
);

   logic             state;        // ST_CMD / ST_DATA
   logic [2:0]       bit_cnt;      // bit within current byte
   logic [7:0]       rx_sr;        // receive shift register
   logic [7:0]       rx_next;      // rx_sr with the bit on mosi inserted
   logic             byte_end;     // last bit of a byte on this edge

   spi_pkg::spi_byte_u rx_byte;    // completed byte incl. current mosi bit
   spi_pkg::spi_byte_u cmd_q;      // opcode + running address

   //##########################################################################
   // receive path
   //##########################################################################

   // lsb first shifts in from the top, msb first from the bottom
   assign rx_next = lsbfirst ? {mosi, rx_sr[7:1]} : {rx_sr[6:0], mosi};

   always_ff @(posedge sclk) begin
      if (spi_en) begin
         rx_sr <= rx_next;
      end
   end

   assign rx_byte  = rx_next;  // eighth bit straight from mosi
   assign byte_end = spi_en & (bit_cnt == 3'd7);

   //##########################################################################
   // frame state and bit count
   //##########################################################################

   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         state   <= spi_pkg::ST_CMD;
         bit_cnt <= 3'd0;
      end else if (spi_en) begin
         bit_cnt <= bit_cnt + 3'd1;  // wraps every byte
         if (byte_end) begin
            state <= spi_pkg::ST_DATA;  // stays there until ss
         end
      end
   end

   // command capture at P8, then one address step per data byte
   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         cmd_q <= '0;
      end else if (byte_end) begin
         if (state == spi_pkg::ST_CMD) begin
            cmd_q <= rx_byte;
         end else begin
            cmd_q.cmd.addr <= cmd_q.cmd.addr + 1'b1;  // wraps 63 -> 0
         end
      end
   end

   //##########################################################################
   // register file side
   //##########################################################################

   assign reg_addr  = cmd_q.cmd.addr;
   assign reg_wdata = rx_byte.data;

   // write lands on the same edge that completes the byte
   assign reg_write = byte_end & (state == spi_pkg::ST_DATA) &
                      (cmd_q.cmd.op == spi_pkg::OP_WR);

   // high from a byte boundary to the next posedge, sampled on the negedge
   // in between by the tx shifter
   assign tx_load = spi_en & (bit_cnt == 3'd0) & (state == spi_pkg::ST_DATA) &
                    (cmd_q.cmd.op == spi_pkg::OP_RD);

   //##########################################################################
   // checks
   //##########################################################################

   // first byte of a frame is never a write
   a_no_write_in_cmd : assert property (
      @(posedge sclk) disable iff (ss)
      $fell(ss) |-> !reg_write [*8]
   );

   // write and read strobes are on opposite byte positions
   a_write_load_excl : assert property (
      @(posedge sclk) disable iff (ss)
      !(reg_write && tx_load)
   );

   // one write per full byte at most
   a_write_spacing : assert property (
      @(posedge sclk) disable iff (ss)
      reg_write |=> (!reg_write) [*7]
   );

endmodule

`default_nettype wire

// File: hw/spi_tx_shift.sv
//##########################################################################
// spi transmit shifter: loads a register byte at each read boundary
// and shifts it out on miso on the falling sclk edge
//##########################################################################
`timescale 1ns/10ps
`default_nettype none

module spi_tx_shift (
   input  wire logic       sclk,
   input  wire logic       ss,          // clears the shifter between frames
   input  wire logic       spi_en,
   input  wire logic       lsbfirst,
   input  wire logic       tx_load,     // byte boundary, read opcode only
   input  wire logic [7:0] reg_rdata,
   output      logic       miso
);

   logic [7:0] tx_sr;  // outgoing byte, zero filled

   // mode 0: change on the falling edge, master samples on the rising one
   always_ff @(negedge sclk or posedge ss) begin
      if (ss) begin
         tx_sr <= 8'd0;
      end else if (tx_load) begin
         tx_sr <= reg_rdata;  // first bit shows up right away
      end else if (spi_en) begin
         if (lsbfirst) begin
            tx_sr <= {1'b0, tx_sr[7:1]};
         end else begin
            tx_sr <= {tx_sr[6:0], 1'b0};
         end
      end
   end

   // current end bit, low whenever disabled
   assign miso = spi_en & (lsbfirst ? tx_sr[0] : tx_sr[7]);

   // framing logic is held in reset while deselected
   a_no_load_deselected : assert property (
      @(negedge sclk) ss |-> !tx_load
   );

endmodule

`default_nettype wire

// File: hw/spi_regfile.sv
//##########################################################################
// 64 x 8 register file, read-only id at the top address,
// register 0 mirrored on ctrl_out
//##########################################################################
`timescale 1ns/10ps
`default_nettype none

module spi_regfile (
   input  wire logic                        sclk,
   input  wire logic                        reg_write,  // write strobe from io
   input  wire logic [spi_pkg::ADDR_W-1:0]  reg_addr,
   input  wire logic [7:0]                  reg_wdata,
   output      logic [7:0]                  reg_rdata,  // combinational read
   output      logic [7:0]                  ctrl_out
);

   logic [7:0] mem [spi_pkg::REG_COUNT];  // flop array, contents undefined at start

   //##########################################################################
   // write port
   //##########################################################################

   always_ff @(posedge sclk) begin
      if (reg_write && (reg_addr != spi_pkg::ID_ADDR)) begin  // id is read-only
         mem[reg_addr] <= reg_wdata;
      end
   end

   //##########################################################################
   // read ports
   //##########################################################################

   // id register overrides the array entry
   always_comb begin
      if (reg_addr == spi_pkg::ID_ADDR) begin
         reg_rdata = spi_pkg::ID_VALUE;
      end else begin
         reg_rdata = mem[reg_addr];
      end
   end

   assign ctrl_out = mem[spi_pkg::CTRL_ADDR];  // control to the core

endmodule

`default_nettype wire

// File: hw/spi_slave.sv
//##########################################################################
// spi slave top: framing, transmit shifter and register file
//##########################################################################
`timescale 1ns/10ps
`default_nettype none

module spi_slave (
   input  wire logic       sclk,
   input  wire logic       ss,
   input  wire logic       mosi,
   input  wire logic       spi_en,
   input  wire logic       lsbfirst,
   output      logic       miso,
   output      logic [7:0] ctrl_out
);

   logic [spi_pkg::ADDR_W-1:0] reg_addr;
   logic [7:0]                 reg_wdata;
   logic [7:0]                 reg_rdata;
   logic                       reg_write;
   logic                       tx_load;

   // frame fsm and receive side
   spi_slave_io i_io (
      .sclk      (sclk),
      .ss        (ss),
      .mosi      (mosi),
      .spi_en    (spi_en),
      .lsbfirst  (lsbfirst),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_write (reg_write),
      .tx_load   (tx_load)
   );

   // miso driver
   spi_tx_shift i_tx (
      .sclk      (sclk),
      .ss        (ss),
      .spi_en    (spi_en),
      .lsbfirst  (lsbfirst),
      .tx_load   (tx_load),
      .reg_rdata (reg_rdata),
      .miso      (miso)
   );

   spi_regfile i_regs (
      .sclk      (sclk),
      .reg_write (reg_write),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_rdata (reg_rdata),
      .ctrl_out  (ctrl_out)
   );

endmodule

`default_nettype wire

// File: sim/tb_spi_slave.sv
//##########################################################################
// testbench for the spi slave: mode 0 master tasks, register model,
// compare tasks, directed tests and a cycle-count timeout
//##########################################################################
`timescale 1ns/10ps
`default_nettype none

module tb_spi_slave;

   typedef logic [7:0] byte_q_t [$];

   localparam int RESET_CYCLES = 10;
   localparam int GAP_CYCLES   = 10;     // ss high between frames
   localparam int FRAME_BYTES  = 71;     // all frames of all tests, command bytes included
   localparam int FRAME_COUNT  = 18;
   // each frame costs its bits, one sync edge and the gap
   localparam int TIMEOUT_CYCLES =
      2 * (FRAME_BYTES * 8 + FRAME_COUNT * (GAP_CYCLES + 1) + RESET_CYCLES);

   logic       sclk;
   logic       ss;
   logic       mosi;
   logic       spi_en;
   logic       lsbfirst;
   logic       miso;
   logic [7:0] ctrl_out;

   logic [7:0]  ref_mem [spi_pkg::REG_COUNT];  // expected register contents
   int          cycle_cnt = 0;
   int unsigned seed_val;

   spi_slave i_dut (
      .sclk     (sclk),
      .ss       (ss),
      .mosi     (mosi),
      .spi_en   (spi_en),
      .lsbfirst (lsbfirst),
      .miso     (miso),
      .ctrl_out (ctrl_out)
   );

   always #2 sclk = ~sclk;  // 4 ns period

   // run limit
   always @(posedge sclk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: tests did not finish within %0d sclk cycles", TIMEOUT_CYCLES);
         $display("FAIL: see errors above");
         $fatal(1, "run stopped by timeout");
      end
   end

   //##########################################################################
   // compare tasks and helpers
   //##########################################################################

   task automatic compare_byte(input spi_pkg::spi_byte_u got, input spi_pkg::spi_byte_u exp,
                               input string what);
      if (got.data !== exp.data) begin
         $display("error at %0t ns: %s: miso byte %02h, expected %02h",
                  $time, what, got.data, exp.data);
         $display("FAIL: see errors above");
         $fatal(1, "miso byte mismatch");
      end
   endtask

   task automatic compare_ctrl(input logic [7:0] got, input logic [7:0] exp, input string what);
      if (got !== exp) begin
         $display("error at %0t ns: %s: ctrl_out %02h, expected %02h", $time, what, got, exp);
         $display("FAIL: see errors above");
         $fatal(1, "ctrl_out mismatch");
      end
   endtask

   function automatic spi_pkg::spi_byte_u make_cmd(input logic [1:0] op,
                                                   input logic [spi_pkg::ADDR_W-1:0] addr);
      spi_pkg::spi_byte_u c;
      c.cmd.op   = op;
      c.cmd.addr = addr;
      return c;
   endfunction

   function automatic logic [7:0] rand_byte();
      logic [31:0] r;
      r = $urandom();
      return r[7:0];
   endfunction

   // what a read of addr must return
   function automatic spi_pkg::spi_byte_u expected_at(input logic [spi_pkg::ADDR_W-1:0] addr);
      spi_pkg::spi_byte_u e;
      e.data = (addr == spi_pkg::ID_ADDR) ? spi_pkg::ID_VALUE : ref_mem[addr];
      return e;
   endfunction

   // model of a write frame; full bytes only, id address ignores writes
   task automatic model_write(input spi_pkg::spi_byte_u cmd, input byte_q_t data);
      logic [spi_pkg::ADDR_W-1:0] addr;
      addr = cmd.cmd.addr;
      if (spi_en && (cmd.cmd.op == spi_pkg::OP_WR)) begin
         foreach (data[k]) begin
            if (addr != spi_pkg::ID_ADDR) begin
               ref_mem[addr] = data[k];
            end
            addr = addr + 6'd1;  // wraps like the dut
         end
      end
   endtask

   //##########################################################################
   // spi master
   //##########################################################################

   // cut_bits > 0 sends only that many bits of the last byte, then drops ss
   task automatic send_frame(input spi_pkg::spi_byte_u cmd, input byte_q_t data,
                             input int cut_bits, output byte_q_t rx_bytes);
      byte_q_t    frame;
      int         n_bits;
      int         pos;
      logic [7:0] rx_cur;
      frame = {};
      rx_bytes = {};
      rx_cur = 8'h00;
      frame.push_back(cmd.data);
      foreach (data[k]) begin
         frame.push_back(data[k]);
      end
      n_bits = 8 * frame.size();
      if (cut_bits > 0) begin
         n_bits = n_bits - 8 + cut_bits;
      end
      @(posedge sclk);
      #0.5;
      ss = 1'b0;
      for (int i = 0; i < n_bits; i++) begin
         pos = lsbfirst ? (i % 8) : (7 - (i % 8));
         mosi = frame[i / 8][pos];
         @(posedge sclk);
         rx_cur[pos] = miso;  // stable, changes on negedge only
         if ((i % 8 == 7) && (i >= 8)) begin
            rx_bytes.push_back(rx_cur);
         end
         #0.5;
      end
      ss = 1'b1;
      mosi = 1'b0;
      repeat (GAP_CYCLES) @(posedge sclk);
   endtask

   task automatic write_regs(input logic [spi_pkg::ADDR_W-1:0] start, input byte_q_t data);
      byte_q_t rx;
      send_frame(make_cmd(spi_pkg::OP_WR, start), data, 0, rx);
      model_write(make_cmd(spi_pkg::OP_WR, start), data);
   endtask

   task automatic check_read(input logic [spi_pkg::ADDR_W-1:0] start, input int count,
                             input string what);
      byte_q_t                    tx;
      byte_q_t                    rx;
      logic [spi_pkg::ADDR_W-1:0] addr;
      spi_pkg::spi_byte_u         got;
      tx = {};
      for (int k = 0; k < count; k++) begin
         tx.push_back(8'h00);
      end
      send_frame(make_cmd(spi_pkg::OP_RD, start), tx, 0, rx);
      addr = start;
      foreach (rx[k]) begin
         got.data = rx[k];
         compare_byte(got, expected_at(addr), what);
         addr = addr + 6'd1;
      end
   endtask

   // every miso byte of a frame must be zero
   task automatic check_zero_miso(input byte_q_t rx, input string what);
      spi_pkg::spi_byte_u got;
      spi_pkg::spi_byte_u zero;
      zero.data = 8'h00;
      foreach (rx[k]) begin
         got.data = rx[k];
         compare_byte(got, zero, what);
      end
   endtask

   //##########################################################################
   // directed tests
   //##########################################################################

   task automatic test_ctrl_write();
      write_regs(spi_pkg::CTRL_ADDR, '{8'h3c});
      compare_ctrl(ctrl_out, 8'h3c, "first write to ctrl");
      write_regs(spi_pkg::CTRL_ADDR, '{8'hc5});
      compare_ctrl(ctrl_out, 8'hc5, "second write to ctrl");
      write_regs(spi_pkg::CTRL_ADDR, '{8'h81, 8'h42, 8'h24});  // burst from 0
      compare_ctrl(ctrl_out, ref_mem[spi_pkg::CTRL_ADDR], "burst write from ctrl");
   endtask

   task automatic test_wrap_read();
      write_regs(6'd60, '{8'ha1, 8'hb2, 8'hc3, 8'hd4});  // last one hits id
      check_read(6'd60, 5, "read 60..63 and wrap to 0");
   endtask

   task automatic test_id_readonly();
      write_regs(spi_pkg::ID_ADDR, '{8'hff});
      check_read(spi_pkg::ID_ADDR, 1, "id after write");
   endtask

   task automatic test_lsb_first();
      byte_q_t data;
      data = {};
      repeat (4) data.push_back(rand_byte());
      lsbfirst = 1'b1;
      write_regs(6'd10, data);
      check_read(6'd10, 4, "lsb first read-back");
      lsbfirst = 1'b0;
      check_read(6'd10, 4, "msb first read of lsb first data");
   endtask

   task automatic test_reserved_and_disabled();
      byte_q_t data;
      byte_q_t rx;
      data = {};
      repeat (4) data.push_back(rand_byte());
      send_frame(make_cmd(2'b01, 6'd10), data, 0, rx);
      check_zero_miso(rx, "reserved opcode 01");
      send_frame(make_cmd(2'b11, 6'd10), data, 0, rx);
      check_zero_miso(rx, "reserved opcode 11");
      spi_en = 1'b0;  // ss is high here
      send_frame(make_cmd(spi_pkg::OP_WR, spi_pkg::CTRL_ADDR), '{8'h11, 8'h22, 8'h33}, 0, rx);
      // an enabled read here would return the lsb test data
      send_frame(make_cmd(spi_pkg::OP_RD, 6'd10), data, 0, rx);
      check_zero_miso(rx, "read frame with spi_en low");
      spi_en = 1'b1;
      compare_ctrl(ctrl_out, ref_mem[spi_pkg::CTRL_ADDR], "ctrl after disabled frame");
      check_read(6'd10, 4, "registers after reserved frames");
   endtask

   task automatic test_ss_abort();
      byte_q_t rx;
      write_regs(6'd30, '{8'h96, 8'h69});
      // second byte cut after 5 bits
      send_frame(make_cmd(spi_pkg::OP_WR, 6'd30), '{8'h0f, 8'hf0}, 5, rx);
      model_write(make_cmd(spi_pkg::OP_WR, 6'd30), '{8'h0f});
      check_read(6'd30, 2, "partial byte dropped on ss");
   endtask

   //##########################################################################
   // main sequence
   //##########################################################################

   initial begin
      sclk     = 1'b0;
      ss       = 1'b1;
      mosi     = 1'b0;
      spi_en   = 1'b1;
      lsbfirst = 1'b0;
      seed_val = $urandom(2561);
      repeat (RESET_CYCLES) @(posedge sclk);
      test_ctrl_write();
      test_wrap_read();
      test_id_readonly();
      test_lsb_first();
      test_reserved_and_disabled();
      test_ss_abort();
      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
hw/spi_pkg.sv
hw/spi_slave_io.sv
hw/spi_tx_shift.sv
hw/spi_regfile.sv
hw/spi_slave.sv
sim/tb_spi_slave.sv

// File: run_sim.sh
#!/bin/sh
# build the spi slave testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f vlog.f --top-module tb_spi_slave -o sim_tb_spi_slave

# exit status of the run is judged from the log below
./obj_dir/sim_tb_spi_slave > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
   echo "simulation failed"
   exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0
